//--- rtl/tetrisPkg.sv
package tetrisPkg;

    //////////////////////////////////////////////////
    // piece box geometry
    //////////////////////////////////////////////////

    localparam int PieceWidth  = 4;
    localparam int PieceHeight = 2;

    // top-left corner of the box at spawn
    localparam int SpawnX = 3;
    localparam int SpawnY = 0;

    // top row first, left to right, so bit r*4+c is cell (r, c)
    typedef logic [0:PieceWidth*PieceHeight-1] pieceT;

    typedef enum logic [2:0] {
        KindI,
        KindT,
        KindO,
        KindS,
        KindZ,
        KindL,
        KindJ
    } pieceKindE;

    // indexed by pieceKindE
    localparam pieceT PieceShapes [7] = '{
        8'b1111_0000,
        8'b0100_1110,
        8'b1100_1100,
        8'b0110_1100,
        8'b1100_0110,
        8'b1110_1000,
        8'b1000_1110
    };

    //////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        Spawn,
        Play,
        Lock,
        Over
    } gameStateE;

endpackage

//--- rtl/buttonEdge.sv
`timescale 1ns/1ps

module buttonEdge (
    input  logic clk,
    input  logic rst_up,
    input  logic button,
    output logic pulse
);

    // [0] and [1] synchronize, [2] holds the previous level
    logic [2:0] history;

    always_ff @(posedge clk) begin
        if (rst_up) begin
            history <= '0;
            pulse   <= 1'b0;
        end else begin
            history <= {history[1:0], button};
            // rising edge only, a held button fires once
            pulse   <= history[1] & ~history[2];
        end
    end

endmodule

//--- rtl/pieceGenerator.sv
`timescale 1ns/1ps

module pieceGenerator (
    input  logic             clk,
    input  logic             rst_up,
    input  logic             advance,
    output tetrisPkg::pieceT currentPiece,
    output tetrisPkg::pieceT nextPiece
);
    import tetrisPkg::*;

    pieceKindE kind;

    // free-running, so the kind taken depends on when the lock lands
    always_ff @(posedge clk) begin
        if (rst_up) begin
            kind         <= KindI;
            currentPiece <= PieceShapes[KindI];
            nextPiece    <= PieceShapes[KindT];
        end else begin
            if (kind == KindJ) begin
                kind <= KindI;
            end else begin
                kind <= pieceKindE'(kind + 3'd1);
            end
            if (advance) begin
                currentPiece <= nextPiece;
                nextPiece    <= PieceShapes[kind];
            end
        end
    end

endmodule

//--- rtl/fallTimer.sv
`timescale 1ns/1ps

module fallTimer #(
    parameter int FallPeriod = 25_000_000
) (
    input  logic clk,
    input  logic rst_up,
    input  logic running,
    input  logic fall,
    output logic fallTick
);

    // room for FallPeriod plus one overshoot count
    localparam int CountW = $clog2(FallPeriod + 2);

    logic [CountW-1:0] count;
    logic [CountW-1:0] sum;

    // soft drop counts double
    assign sum = count + (fall ? CountW'(2) : CountW'(1));

    always_ff @(posedge clk) begin
        if (rst_up) begin
            count    <= '0;
            fallTick <= 1'b0;
        end else begin
            fallTick <= 1'b0;
            if (running) begin
                if (sum >= FallPeriod) begin
                    count    <= '0;
                    fallTick <= 1'b1;
                end else begin
                    count <= sum;
                end
            end
        end
    end

endmodule

//--- rtl/boardStore.sv
`timescale 1ns/1ps

module boardStore #(
    parameter int BoardRows = 20,
    parameter int BoardCols = 10
) (
    input  logic                         clk,
    input  logic                         rst_up,
    input  tetrisPkg::pieceT             currentPiece,
    input  logic [$clog2(BoardCols):0]   probeX,
    input  logic [$clog2(BoardRows):0]   probeY,
    output logic                         probeHit,
    input  logic                         lockPiece,
    input  logic [$clog2(BoardCols)-1:0] pieceX,
    input  logic [$clog2(BoardRows)-1:0] pieceY,
    input  logic [$clog2(BoardRows)-1:0] cellRow,
    input  logic [$clog2(BoardCols)-1:0] cellCol,
    output logic                         cellFilled
);
    import tetrisPkg::*;

    typedef logic [BoardCols-1:0] rowT;

    rowT  settled   [BoardRows];
    rowT  merged    [BoardRows];
    rowT  compacted [BoardRows];
    logic pieceCover;
    logic settledCell;

    //////////////////////////////////////////////////
    // collision probe
    //////////////////////////////////////////////////

    // walls and floor count as hits, the top is never probed above row 0
    always_comb begin
        probeHit = 1'b0;
        for (int r = 0; r < PieceHeight; r++) begin
            for (int c = 0; c < PieceWidth; c++) begin
                if (currentPiece[r*PieceWidth + c]) begin
                    if ((probeX + c) >= BoardCols || (probeY + r) >= BoardRows) begin
                        probeHit = 1'b1;
                    end else if (settled[probeY + r][probeX + c]) begin
                        probeHit = 1'b1;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // lock and line clear
    //////////////////////////////////////////////////

    always_comb begin
        merged = settled;
        for (int r = 0; r < PieceHeight; r++) begin
            for (int c = 0; c < PieceWidth; c++) begin
                if (currentPiece[r*PieceWidth + c] &&
                    (pieceY + r) < BoardRows && (pieceX + c) < BoardCols) begin
                    merged[pieceY + r][pieceX + c] = 1'b1;
                end
            end
        end
    end

    // surviving rows slide to the bottom, empty rows fill in from the top
    always_comb begin : compactRows
        int writeRow;
        compacted = '{default: '0};
        writeRow  = BoardRows - 1;
        for (int i = BoardRows - 1; i >= 0; i--) begin
            if (!(&merged[i])) begin
                compacted[writeRow] = merged[i];
                writeRow            = writeRow - 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_up) begin
            settled <= '{default: '0};
        end else if (lockPiece) begin
            settled <= compacted;
        end
    end

    //////////////////////////////////////////////////
    // cell readout
    //////////////////////////////////////////////////

    always_comb begin
        pieceCover = 1'b0;
        for (int r = 0; r < PieceHeight; r++) begin
            for (int c = 0; c < PieceWidth; c++) begin
                if (currentPiece[r*PieceWidth + c] &&
                    (pieceX + c) == cellCol && (pieceY + r) == cellRow) begin
                    pieceCover = 1'b1;
                end
            end
        end
    end

    assign settledCell = (cellRow < BoardRows && cellCol < BoardCols) ?
                         settled[cellRow][cellCol] : 1'b0;
    assign cellFilled  = settledCell | pieceCover;

endmodule

//--- rtl/gameControl.sv
`timescale 1ns/1ps

module gameControl #(
    parameter int BoardRows = 20,
    parameter int BoardCols = 10
) (
    input  logic                         clk,
    input  logic                         rst_up,
    input  logic                         pause,
    input  logic                         leftPulse,
    input  logic                         rightPulse,
    input  logic                         fallTick,
    input  logic                         probeHit,
    output logic [$clog2(BoardCols):0]   probeX,
    output logic [$clog2(BoardRows):0]   probeY,
    output logic [$clog2(BoardCols)-1:0] pieceX,
    output logic [$clog2(BoardRows)-1:0] pieceY,
    output logic                         lockPiece,
    output logic                         advance,
    output logic                         gameOver,
    output logic                         running
);
    import tetrisPkg::*;

    localparam int ColW = $clog2(BoardCols);
    localparam int RowW = $clog2(BoardRows);

    localparam logic [ColW-1:0] SpawnCol = ColW'(SpawnX);
    localparam logic [RowW-1:0] SpawnRow = RowW'(SpawnY);

    gameStateE state;
    logic      fallPending;
    logic      tryLeft;
    logic      tryRight;
    logic      tryDown;

    assign running   = ~pause && (state != Over);
    assign lockPiece = (state == Lock);
    assign advance   = (state == Lock);

    //////////////////////////////////////////////////
    // candidate position
    //////////////////////////////////////////////////

    // spawn, left, right, down; one probe per cycle
    always_comb begin
        tryLeft  = 1'b0;
        tryRight = 1'b0;
        tryDown  = 1'b0;
        probeX   = {1'b0, pieceX};
        probeY   = {1'b0, pieceY};
        if (state == Spawn) begin
            probeX = {1'b0, SpawnCol};
            probeY = {1'b0, SpawnRow};
        end else if (state == Play && running) begin
            if (leftPulse) begin
                tryLeft = 1'b1;
                // wraps to a large column at the wall, which the probe rejects
                probeX  = {1'b0, pieceX} - 1'b1;
            end else if (rightPulse) begin
                tryRight = 1'b1;
                probeX   = {1'b0, pieceX} + 1'b1;
            end else if (fallTick || fallPending) begin
                tryDown = 1'b1;
                probeY  = {1'b0, pieceY} + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // state and position
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_up) begin
            state       <= Spawn;
            pieceX      <= SpawnCol;
            pieceY      <= SpawnRow;
            gameOver    <= 1'b0;
            fallPending <= 1'b0;
        end else begin
            case (state)
                Spawn: begin
                    pieceX      <= SpawnCol;
                    pieceY      <= SpawnRow;
                    fallPending <= 1'b0;
                    if (probeHit) begin
                        state    <= Over;
                        gameOver <= 1'b1;
                    end else begin
                        state <= Play;
                    end
                end
                Play: begin
                    // a tick that loses to a move is served next cycle
                    if (tryDown) begin
                        fallPending <= 1'b0;
                    end else if (fallTick) begin
                        fallPending <= 1'b1;
                    end
                    if ((tryLeft || tryRight) && !probeHit) begin
                        pieceX <= probeX[ColW-1:0];
                    end
                    if (tryDown) begin
                        if (probeHit) begin
                            state <= Lock;
                        end else begin
                            pieceY <= probeY[RowW-1:0];
                        end
                    end
                end
                Lock: begin
                    state <= Spawn;
                end
                Over: begin
                    // held until reset
                    state <= Over;
                end
                default: begin
                    state <= Spawn;
                end
            endcase
        end
    end

endmodule

//--- rtl/tetrisTop.sv
`timescale 1ns/1ps

module tetrisTop #(
    parameter int BoardRows  = 20,
    parameter int BoardCols  = 10,
    parameter int FallPeriod = 25_000_000
) (
    input  logic                         clk,
    input  logic                         rst_up,
    input  logic                         left,
    input  logic                         right,
    input  logic                         fall,
    input  logic                         pause,
    input  logic [$clog2(BoardRows)-1:0] cellRow,
    input  logic [$clog2(BoardCols)-1:0] cellCol,
    output logic                         cellFilled,
    output tetrisPkg::pieceT             nextPiece,
    output logic [$clog2(BoardCols)-1:0] pieceX,
    output logic [$clog2(BoardRows)-1:0] pieceY,
    output logic                         gameOver,
    output logic                         running
);
    import tetrisPkg::*;

    localparam int ColW = $clog2(BoardCols);
    localparam int RowW = $clog2(BoardRows);

    logic          leftPulse;
    logic          rightPulse;
    logic          fallTick;
    logic          advance;
    logic          lockPiece;
    logic          probeHit;
    logic [ColW:0] probeX;
    logic [RowW:0] probeY;
    pieceT         currentPiece;

    buttonEdge leftEdge (
        .clk    (clk),
        .rst_up (rst_up),
        .button (left),
        .pulse  (leftPulse)
    );

    buttonEdge rightEdge (
        .clk    (clk),
        .rst_up (rst_up),
        .button (right),
        .pulse  (rightPulse)
    );

    pieceGenerator generator (
        .clk          (clk),
        .rst_up       (rst_up),
        .advance      (advance),
        .currentPiece (currentPiece),
        .nextPiece    (nextPiece)
    );

    fallTimer #(
        .FallPeriod (FallPeriod)
    ) timer (
        .clk      (clk),
        .rst_up   (rst_up),
        .running  (running),
        .fall     (fall),
        .fallTick (fallTick)
    );

    boardStore #(
        .BoardRows (BoardRows),
        .BoardCols (BoardCols)
    ) board (
        .clk          (clk),
        .rst_up       (rst_up),
        .currentPiece (currentPiece),
        .probeX       (probeX),
        .probeY       (probeY),
        .probeHit     (probeHit),
        .lockPiece    (lockPiece),
        .pieceX       (pieceX),
        .pieceY       (pieceY),
        .cellRow      (cellRow),
        .cellCol      (cellCol),
        .cellFilled   (cellFilled)
    );

    gameControl #(
        .BoardRows (BoardRows),
        .BoardCols (BoardCols)
    ) control (
        .clk        (clk),
        .rst_up     (rst_up),
        .pause      (pause),
        .leftPulse  (leftPulse),
        .rightPulse (rightPulse),
        .fallTick   (fallTick),
        .probeHit   (probeHit),
        .probeX     (probeX),
        .probeY     (probeY),
        .pieceX     (pieceX),
        .pieceY     (pieceY),
        .lockPiece  (lockPiece),
        .advance    (advance),
        .gameOver   (gameOver),
        .running    (running)
    );

endmodule

//--- verification/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    input  logic restart,
    output logic clk,
    output logic rst_up
);

    logic startup;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // held for two cycles, released on a falling edge
    initial begin
        startup = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        startup = 1'b0;
    end

    assign rst_up = startup | restart;

endmodule

//--- verification/tetrisTb.sv
`timescale 1ns/1ps

module tetrisTb;
    import tetrisPkg::*;

    localparam int BoardRows    = 20;
    localparam int BoardCols    = 10;
    localparam int FallPeriod   = 16;
    localparam int RandomPieces = 10;
    localparam int PieceCycles  = BoardRows * FallPeriod + 10 * BoardCols +
                                  BoardRows * BoardCols + 20;
    localparam int ScriptCycles = PieceCycles * (RandomPieces + BoardRows + 1) + 400;

    logic       clk;
    logic       rst_up;
    logic       restart;
    logic       left;
    logic       right;
    logic       fall;
    logic       pause;
    logic [4:0] cellRow;
    logic [3:0] cellCol;
    logic       cellFilled;
    pieceT      nextPiece;
    logic [3:0] pieceX;
    logic [4:0] pieceY;
    logic       gameOver;
    logic       running;

    int                   errors;
    int                   settledCount;
    int                   lockCount;
    logic [31:0]          lfsr;
    pieceT                curShape;
    pieceT                lockShapes [$];
    int                   lockXs [$];
    int                   lockYs [$];
    logic [BoardCols-1:0] model [BoardRows];
    logic [BoardCols-1:0] seen  [BoardRows];
    logic [4:0]           lastY;
    logic                 lastFall;
    logic                 gapValid;
    logic                 fallMixed;
    int                   fallGap;

    tbClock clockGen (
        .restart (restart),
        .clk     (clk),
        .rst_up  (rst_up)
    );

    tetrisTop #(
        .BoardRows  (BoardRows),
        .BoardCols  (BoardCols),
        .FallPeriod (FallPeriod)
    ) dut_i (
        .clk        (clk),
        .rst_up     (rst_up),
        .left       (left),
        .right      (right),
        .fall       (fall),
        .pause      (pause),
        .cellRow    (cellRow),
        .cellCol    (cellCol),
        .cellFilled (cellFilled),
        .nextPiece  (nextPiece),
        .pieceX     (pieceX),
        .pieceY     (pieceY),
        .gameOver   (gameOver),
        .running    (running)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // fibonacci lfsr with taps 32 22 2 1
    function automatic int randomBits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    function automatic int lastColumn(input pieceT s);
        int lastCol;
        lastCol = 0;
        for (int r = 0; r < PieceHeight; r++) begin
            for (int c = 0; c < PieceWidth; c++) begin
                if (s[r*PieceWidth + c] && c > lastCol) begin
                    lastCol = c;
                end
            end
        end
        return lastCol;
    endfunction

    // the seven two-by-four shapes
    function automatic logic knownShape(input pieceT s);
        case (s)
            8'b1111_0000, 8'b0100_1110, 8'b1100_1100, 8'b0110_1100,
            8'b1100_0110, 8'b1110_1000, 8'b1000_1110: begin
                return 1'b1;
            end
            default: begin
                return 1'b0;
            end
        endcase
    endfunction

    function automatic logic covers(input pieceT s, input int x, input int y,
                                    input int r, input int c);
        int rr;
        int cc;
        rr = r - y;
        cc = c - x;
        if (rr < 0 || rr >= PieceHeight || cc < 0 || cc >= PieceWidth) begin
            return 1'b0;
        end
        return s[rr*PieceWidth + cc];
    endfunction

    task automatic checkValue(input string name, input int got, input int want);
        assert (got == want) else begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    // one button edge and enough cycles for the move to land
    task automatic tap(input logic toRight);
        if (toRight) begin
            right = 1'b1;
        end else begin
            left = 1'b1;
        end
        @(negedge clk);
        right = 1'b0;
        left  = 1'b0;
        repeat (4 + randomBits(2)) @(negedge clk);
    endtask

    // reference board merges each locked piece and drops full rows
    task automatic applyLock;
        logic [BoardCols-1:0] squeezed [BoardRows];
        pieceT                shape;
        int                   x;
        int                   y;
        int                   full;
        int                   writeRow;
        while (lockShapes.size() > 0) begin
            shape = lockShapes.pop_front();
            x     = lockXs.pop_front();
            y     = lockYs.pop_front();
            for (int r = 0; r < BoardRows; r++) begin
                for (int c = 0; c < BoardCols; c++) begin
                    if (covers(shape, x, y, r, c)) begin
                        model[r][c] = 1'b1;
                    end
                end
            end
            full     = 0;
            writeRow = BoardRows - 1;
            squeezed = '{default: '0};
            for (int r = BoardRows - 1; r >= 0; r--) begin
                if (&model[r]) begin
                    full++;
                end else begin
                    squeezed[writeRow] = model[r];
                    writeRow--;
                end
            end
            model        = squeezed;
            settledCount = settledCount + $countones(shape) - BoardCols * full;
        end
    endtask

    // frozen readout scan against the reference board
    task automatic checkBoard;
        int   filled;
        logic want;
        pause = 1'b1;
        repeat (3) @(negedge clk);
        filled = 0;
        for (int r = 0; r < BoardRows; r++) begin
            for (int c = 0; c < BoardCols; c++) begin
                @(negedge clk);
                cellRow = 5'(r);
                cellCol = 4'(c);
                #1;
                seen[r][c] = cellFilled;
                filled     = filled + int'(cellFilled);
                want       = model[r][c] | covers(curShape, pieceX, pieceY, r, c);
                if (!gameOver) begin
                    assert (cellFilled == want) else begin
                        errors++;
                        $display("mismatch cellFilled row %0d col %0d: got %h expected %h",
                                 r, c, cellFilled, want);
                    end
                end
            end
        end
        if (!gameOver) begin
            checkValue("filled cell count", filled, settledCount + $countones(curShape));
            for (int r = 0; r < BoardRows; r++) begin
                assert (!(&seen[r])) else begin
                    errors++;
                    $display("row %0d is still entirely filled after a lock", r);
                end
            end
        end
        @(negedge clk);
        pause = 1'b0;
    endtask

    task automatic waitLock;
        int startCount;
        startCount = lockCount;
        while (lockCount == startCount && !gameOver) @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // scenarios
    //////////////////////////////////////////////////

    task automatic moveChecks;
        int expX;
        int maxX;
        maxX = BoardCols - 1 - lastColumn(curShape);
        expX = pieceX;
        // held button moves once
        left = 1'b1;
        repeat (12) @(negedge clk);
        left = 1'b0;
        repeat (5) @(negedge clk);
        expX = (expX > 0) ? expX - 1 : 0;
        checkValue("pieceX", pieceX, expX);
        repeat (4) begin
            tap(1'b0);
            expX = (expX > 0) ? expX - 1 : 0;
            checkValue("pieceX", pieceX, expX);
        end
        repeat (BoardCols) begin
            tap(1'b1);
            expX = (expX < maxX) ? expX + 1 : maxX;
            checkValue("pieceX", pieceX, expX);
        end
    endtask

    task automatic pauseChecks;
        int holdX;
        int holdY;
        pause = 1'b1;
        @(negedge clk);
        holdX = pieceX;
        holdY = pieceY;
        tap(1'b0);
        tap(1'b1);
        repeat (2 * FallPeriod) @(negedge clk);
        checkValue("running", running, 0);
        checkValue("pieceX", pieceX, holdX);
        checkValue("pieceY", pieceY, holdY);
        pause = 1'b0;
    endtask

    task automatic placePiece;
        int target;
        int maxX;
        int tries;
        int startCount;
        startCount = lockCount;
        maxX       = BoardCols - 1 - lastColumn(curShape);
        target     = randomBits(4) % (maxX + 1);
        fall       = randomBits(1);
        tries      = 0;
        while (pieceX != target && tries < BoardCols && lockCount == startCount) begin
            tap(pieceX < target);
            tries++;
        end
        while (lockCount == startCount && !gameOver) @(negedge clk);
        fall = 1'b0;
        applyLock();
        checkBoard();
    endtask

    //////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////

    // shape tracking and the position of each lock
    always @(posedge clk) begin
        if (rst_up) begin
            curShape = PieceShapes[KindI];
            lockShapes.delete();
            lockXs.delete();
            lockYs.delete();
            lockCount <= 0;
        end else if (dut_i.lockPiece) begin
            assert (knownShape(nextPiece)) else begin
                errors++;
                $display("nextPiece %h is not one of the seven shapes", nextPiece);
            end
            lockShapes.push_back(curShape);
            lockXs.push_back(int'(pieceX));
            lockYs.push_back(int'(pieceY));
            curShape = nextPiece;
            lockCount <= lockCount + 1;
        end
    end

    // gap between row changes in running cycles
    always @(posedge clk) begin
        if (rst_up) begin
            lastY     <= 5'(SpawnY);
            lastFall  <= 1'b0;
            gapValid  <= 1'b0;
            fallMixed <= 1'b0;
            fallGap   <= 0;
        end else begin
            lastY    <= pieceY;
            lastFall <= fall;
            if (pieceY != lastY) begin
                if (gapValid && pieceY == 5'(lastY + 1) && !fallMixed) begin
                    if (lastFall) begin
                        assert (fallGap + 1 <= FallPeriod / 2 + 1) else begin
                            errors++;
                            $display("soft drop row change took %0d cycles", fallGap + 1);
                        end
                    end else begin
                        assert (fallGap + 1 >= FallPeriod - 1) else begin
                            errors++;
                            $display("row change came after only %0d cycles", fallGap + 1);
                        end
                    end
                end
                gapValid  <= (pieceY == 5'(lastY + 1));
                fallMixed <= 1'b0;
                fallGap   <= 0;
            end else begin
                if (fall != lastFall) begin
                    fallMixed <= 1'b1;
                end
                if (running) begin
                    fallGap <= fallGap + 1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst_up) pause |-> !running)
        else begin
            errors++;
            $display("mismatch running: got %h expected %h", running, 1'b0);
        end

    assert property (@(posedge clk) disable iff (rst_up)
        gameOver |=> (gameOver && !running && $stable(pieceX) && $stable(pieceY)))
        else begin
            errors++;
            $display("game over did not hold the piece, pieceX %h pieceY %h", pieceX, pieceY);
        end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        errors       = 0;
        settledCount = 0;
        lfsr         = 32'h86a3675c;
        restart      = 1'b0;
        left         = 1'b0;
        right        = 1'b0;
        fall         = 1'b0;
        pause        = 1'b0;
        cellRow      = '0;
        cellCol      = '0;
        model        = '{default: '0};
        while (rst_up !== 1'b0) @(posedge clk);
        @(negedge clk);

        checkValue("pieceX", pieceX, SpawnX);
        checkValue("pieceY", pieceY, SpawnY);
        checkValue("gameOver", gameOver, 0);
        checkValue("running", running, 1);
        checkBoard();

        moveChecks();
        pauseChecks();
        waitLock();
        applyLock();
        checkBoard();

        repeat (RandomPieces) begin
            if (!gameOver) begin
                placePiece();
            end
        end

        // straight drops in the spawn columns until a spawn overlaps
        fall = 1'b1;
        while (!gameOver) begin
            waitLock();
            applyLock();
            checkBoard();
        end
        checkValue("gameOver", gameOver, 1);
        checkValue("running", running, 0);
        tap(1'b0);
        tap(1'b1);
        repeat (2 * FallPeriod) @(negedge clk);
        checkValue("pieceX", pieceX, SpawnX);
        checkValue("pieceY", pieceY, SpawnY);
        fall = 1'b0;

        restart = 1'b1;
        repeat (2) @(negedge clk);
        restart      = 1'b0;
        model        = '{default: '0};
        settledCount = 0;
        @(negedge clk);
        checkValue("gameOver", gameOver, 0);
        checkValue("running", running, 1);
        checkValue("pieceX", pieceX, SpawnX);
        checkBoard();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog with a 50 percent margin
    initial begin
        repeat (ScriptCycles * 3 / 2) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", ScriptCycles * 3 / 2);
        $display("errors: %0d", errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- list.f
rtl/tetrisPkg.sv
rtl/buttonEdge.sv
rtl/pieceGenerator.sv
rtl/fallTimer.sv
rtl/boardStore.sv
rtl/gameControl.sv
rtl/tetrisTop.sv
verification/tbClock.sv
verification/tetrisTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tetrisTb
FILELIST  ?= list.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
